/* common/id_macros.svh */
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// widths
`define ID_WORD_W      32
`define ID_REG_ADDR_W  5
`define ID_REG_NUM     32
`define ID_LINK_REG    5'd31

// opcodes, inst[31:26]
`define ID_OP_SPECIAL  6'b000000
`define ID_OP_REGIMM   6'b000001
`define ID_OP_J        6'b000010
`define ID_OP_JAL      6'b000011
`define ID_OP_BEQ      6'b000100
`define ID_OP_BNE      6'b000101
`define ID_OP_BLEZ     6'b000110
`define ID_OP_BGTZ     6'b000111
`define ID_OP_ADDI     6'b001000
`define ID_OP_ADDIU    6'b001001
`define ID_OP_SLTI     6'b001010
`define ID_OP_SLTIU    6'b001011
`define ID_OP_ANDI     6'b001100
`define ID_OP_ORI      6'b001101
`define ID_OP_XORI     6'b001110
`define ID_OP_LUI      6'b001111
`define ID_OP_PREF     6'b110011

// SPECIAL function codes, inst[5:0]
`define ID_FN_SLL      6'b000000
`define ID_FN_SRL      6'b000010
`define ID_FN_SRA      6'b000011
`define ID_FN_SLLV     6'b000100
`define ID_FN_SRLV     6'b000110
`define ID_FN_SRAV     6'b000111
`define ID_FN_JR       6'b001000
`define ID_FN_JALR     6'b001001
`define ID_FN_SYNC     6'b001111
`define ID_FN_ADD      6'b100000
`define ID_FN_ADDU     6'b100001
`define ID_FN_SUB      6'b100010
`define ID_FN_SUBU     6'b100011
`define ID_FN_AND      6'b100100
`define ID_FN_OR       6'b100101
`define ID_FN_XOR      6'b100110
`define ID_FN_NOR      6'b100111
`define ID_FN_SLT      6'b101010
`define ID_FN_SLTU     6'b101011

// REGIMM rt codes, inst[20:16]
`define ID_RT_BLTZ     5'b00000
`define ID_RT_BGEZ     5'b00001
`define ID_RT_BLTZAL   5'b10000
`define ID_RT_BGEZAL   5'b10001

`endif

/* common/id_pkg.sv */
`include "id_macros.svh"

package id_pkg;

	typedef logic [`ID_WORD_W-1:0] word_t;
	typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

	// encodings match the execute stage
	typedef enum logic [7:0] {
		ALU_NOP = 8'b00000000,
		ALU_OR = 8'b00100101, ALU_AND = 8'b00100100,
		ALU_XOR = 8'b00100110, ALU_NOR = 8'b00100111,
		ALU_SLL = 8'b01111100, ALU_SRL = 8'b00000010, ALU_SRA = 8'b00000011,
		ALU_ADD = 8'b00100000, ALU_ADDU = 8'b00100001,
		ALU_ADDI = 8'b01010101, ALU_ADDIU = 8'b01010110,
		ALU_SUB = 8'b00100010, ALU_SUBU = 8'b00100011,
		ALU_SLT = 8'b00101010, ALU_SLTU = 8'b00101011,
		ALU_J = 8'b01001111, ALU_JAL = 8'b01010000,
		ALU_JR = 8'b00001000, ALU_JALR = 8'b00001001,
		ALU_BEQ = 8'b01010001, ALU_BNE = 8'b01010010,
		ALU_BGTZ = 8'b01010100, ALU_BLEZ = 8'b01010011,
		ALU_BGEZ = 8'b01000001, ALU_BGEZAL = 8'b01001011,
		ALU_BLTZ = 8'b01000000, ALU_BLTZAL = 8'b01001010
	} aluop_t;

	typedef enum logic [2:0] {
		RES_NOP = 3'b000,
		RES_LOGIC = 3'b001,
		RES_SHIFT = 3'b010,
		RES_ARITH = 3'b100,
		RES_JUMP_BRANCH = 3'b110
	} alusel_t;

	typedef enum logic [3:0] {
		BR_NONE, BR_JUMP_ABS, BR_JUMP_REG,
		BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
	} branch_kind_t;

endpackage

/* decode/inst_decoder.sv */
`timescale 1ns/10ps
`include "id_macros.svh"

module inst_decoder (
	input  logic                   arst_n_i,
	input  id_pkg::word_t          inst_i,
	output id_pkg::aluop_t         aluop_o,
	output id_pkg::alusel_t        alusel_o,
	output id_pkg::reg_addr_t      wd_o,
	output logic                   wreg_o,
	output logic                   reg1_read_o,
	output logic                   reg2_read_o,
	output id_pkg::reg_addr_t      reg1_addr_o,
	output id_pkg::reg_addr_t      reg2_addr_o,
	output id_pkg::word_t          imm_o,
	output id_pkg::branch_kind_t   branch_kind_o
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] sa;
	logic [15:0] imm16;
	id_pkg::reg_addr_t rs;
	id_pkg::reg_addr_t rt;
	id_pkg::reg_addr_t rd;
	logic const_shift;

	assign opcode = inst_i[31:26];
	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign sa = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm16 = inst_i[15:0];
	assign const_shift = (funct == `ID_FN_SLL) || (funct == `ID_FN_SRL) || (funct == `ID_FN_SRA);

	always_comb begin
		aluop_o = id_pkg::ALU_NOP;
		wd_o = rd;
		wreg_o = 1'b0;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		reg1_addr_o = rs;
		reg2_addr_o = rt;
		imm_o = '0;
		branch_kind_o = id_pkg::BR_NONE;
		if (!arst_n_i) begin
			wd_o = '0;
			reg1_addr_o = '0;
			reg2_addr_o = '0;
		end else begin
			case (opcode)
			`ID_OP_SPECIAL: begin
				case (funct)
				`ID_FN_OR:   aluop_o = id_pkg::ALU_OR;
				`ID_FN_AND:  aluop_o = id_pkg::ALU_AND;
				`ID_FN_XOR:  aluop_o = id_pkg::ALU_XOR;
				`ID_FN_NOR:  aluop_o = id_pkg::ALU_NOR;
				`ID_FN_SLLV, `ID_FN_SLL: aluop_o = id_pkg::ALU_SLL;
				`ID_FN_SRLV, `ID_FN_SRL: aluop_o = id_pkg::ALU_SRL;
				`ID_FN_SRAV, `ID_FN_SRA: aluop_o = id_pkg::ALU_SRA;
				`ID_FN_ADD:  aluop_o = id_pkg::ALU_ADD;
				`ID_FN_ADDU: aluop_o = id_pkg::ALU_ADDU;
				`ID_FN_SUB:  aluop_o = id_pkg::ALU_SUB;
				`ID_FN_SUBU: aluop_o = id_pkg::ALU_SUBU;
				`ID_FN_SLT:  aluop_o = id_pkg::ALU_SLT;
				`ID_FN_SLTU: aluop_o = id_pkg::ALU_SLTU;
				`ID_FN_JR:   aluop_o = id_pkg::ALU_JR;
				`ID_FN_JALR: aluop_o = id_pkg::ALU_JALR;
				`ID_FN_SYNC: aluop_o = id_pkg::ALU_NOP;
				default:     aluop_o = id_pkg::ALU_NOP;
				endcase
				if (const_shift) begin
					// shift amount on operand 1, rt on operand 2
					reg2_read_o = 1'b1;
					imm_o = {{(`ID_WORD_W-5){1'b0}}, sa};
					if (rs != '0)
						aluop_o = id_pkg::ALU_NOP;
				end else begin
					reg1_read_o = 1'b1;
					reg2_read_o = (funct != `ID_FN_JR) && (funct != `ID_FN_JALR);
					if (sa != '0)
						aluop_o = id_pkg::ALU_NOP;
				end
				wreg_o = (funct != `ID_FN_JR);
				if ((funct == `ID_FN_JR) || (funct == `ID_FN_JALR))
					branch_kind_o = id_pkg::BR_JUMP_REG;
			end
			`ID_OP_J: begin
				aluop_o = id_pkg::ALU_J;
				branch_kind_o = id_pkg::BR_JUMP_ABS;
			end
			`ID_OP_JAL: begin
				aluop_o = id_pkg::ALU_JAL;
				branch_kind_o = id_pkg::BR_JUMP_ABS;
				wreg_o = 1'b1;
				wd_o = `ID_LINK_REG;
			end
			`ID_OP_BEQ, `ID_OP_BNE: begin
				aluop_o = (opcode == `ID_OP_BEQ) ? id_pkg::ALU_BEQ : id_pkg::ALU_BNE;
				branch_kind_o = (opcode == `ID_OP_BEQ) ? id_pkg::BR_EQ : id_pkg::BR_NE;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
			end
			`ID_OP_BLEZ, `ID_OP_BGTZ: begin
				aluop_o = (opcode == `ID_OP_BLEZ) ? id_pkg::ALU_BLEZ : id_pkg::ALU_BGTZ;
				branch_kind_o = (opcode == `ID_OP_BLEZ) ? id_pkg::BR_LEZ : id_pkg::BR_GTZ;
				reg1_read_o = 1'b1;
			end
			`ID_OP_REGIMM: begin
				reg1_read_o = 1'b1;
				case (rt)
				`ID_RT_BLTZ: begin
					aluop_o = id_pkg::ALU_BLTZ;
					branch_kind_o = id_pkg::BR_LTZ;
				end
				`ID_RT_BGEZ: begin
					aluop_o = id_pkg::ALU_BGEZ;
					branch_kind_o = id_pkg::BR_GEZ;
				end
				`ID_RT_BLTZAL: begin
					aluop_o = id_pkg::ALU_BLTZAL;
					branch_kind_o = id_pkg::BR_LTZ;
				end
				`ID_RT_BGEZAL: begin
					aluop_o = id_pkg::ALU_BGEZAL;
					branch_kind_o = id_pkg::BR_GEZ;
				end
				default: aluop_o = id_pkg::ALU_NOP;
				endcase
				// linking forms write r31 even when not taken
				wreg_o = (rt == `ID_RT_BLTZAL) || (rt == `ID_RT_BGEZAL);
				wd_o = `ID_LINK_REG;
			end
			`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI, `ID_OP_LUI,
			`ID_OP_ADDI, `ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU: begin
				case (opcode)
				`ID_OP_ORI:   aluop_o = id_pkg::ALU_OR;
				`ID_OP_ANDI:  aluop_o = id_pkg::ALU_AND;
				`ID_OP_XORI:  aluop_o = id_pkg::ALU_XOR;
				`ID_OP_LUI:   aluop_o = id_pkg::ALU_OR;
				`ID_OP_ADDI:  aluop_o = id_pkg::ALU_ADDI;
				`ID_OP_ADDIU: aluop_o = id_pkg::ALU_ADDIU;
				`ID_OP_SLTI:  aluop_o = id_pkg::ALU_SLT;
				default:      aluop_o = id_pkg::ALU_SLTU;
				endcase
				if (opcode == `ID_OP_LUI)
					imm_o = {imm16, {(`ID_WORD_W-16){1'b0}}};
				else if ((opcode == `ID_OP_ORI) || (opcode == `ID_OP_ANDI) || (opcode == `ID_OP_XORI))
					imm_o = {{(`ID_WORD_W-16){1'b0}}, imm16};
				else
					imm_o = {{(`ID_WORD_W-16){imm16[15]}}, imm16};
				reg1_read_o = 1'b1;
				wreg_o = 1'b1;
				wd_o = rt;
			end
			`ID_OP_PREF: aluop_o = id_pkg::ALU_NOP;
			default:     aluop_o = id_pkg::ALU_NOP;
			endcase
		end
		// nop, sync, pref and unknown words leave no side effects
		if (aluop_o == id_pkg::ALU_NOP) begin
			wreg_o = 1'b0;
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			imm_o = '0;
			branch_kind_o = id_pkg::BR_NONE;
		end
	end

	always_comb begin
		case (aluop_o)
		id_pkg::ALU_OR, id_pkg::ALU_AND, id_pkg::ALU_XOR, id_pkg::ALU_NOR:
			alusel_o = id_pkg::RES_LOGIC;
		id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA:
			alusel_o = id_pkg::RES_SHIFT;
		id_pkg::ALU_ADD, id_pkg::ALU_ADDU, id_pkg::ALU_ADDI, id_pkg::ALU_ADDIU,
		id_pkg::ALU_SUB, id_pkg::ALU_SUBU, id_pkg::ALU_SLT, id_pkg::ALU_SLTU:
			alusel_o = id_pkg::RES_ARITH;
		id_pkg::ALU_NOP:
			alusel_o = id_pkg::RES_NOP;
		default:
			alusel_o = id_pkg::RES_JUMP_BRANCH;
		endcase
	end

endmodule

/* decode/branch_unit.sv */
`timescale 1ns/10ps
`include "id_macros.svh"

module branch_unit (
	input  logic                  arst_n_i,
	input  id_pkg::word_t         pc_i,
	input  id_pkg::word_t         inst_i,
	input  id_pkg::branch_kind_t  kind_i,
	input  id_pkg::word_t         reg1_i,
	input  id_pkg::word_t         reg2_i,
	output logic                  branch_flag_o,
	output id_pkg::word_t         branch_addr_o,
	output id_pkg::word_t         link_addr_o,
	output logic                  next_inst_in_delayslot_o
);

	id_pkg::word_t pc_plus_4;
	id_pkg::word_t pc_plus_8;
	id_pkg::word_t rel_target;
	id_pkg::word_t abs_target;
	id_pkg::word_t target;
	logic cond;
	logic is_link;

	assign pc_plus_4 = pc_i + id_pkg::word_t'(4);
	assign pc_plus_8 = pc_i + id_pkg::word_t'(8);
	assign rel_target = pc_plus_4 + {{(`ID_WORD_W-18){inst_i[15]}}, inst_i[15:0], 2'b00};
	assign abs_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

	// JAL, JALR, BLTZAL and BGEZAL, only if the decoder accepted the word
	assign is_link = (kind_i != id_pkg::BR_NONE) &&
		((inst_i[31:26] == `ID_OP_JAL) ||
		((inst_i[31:26] == `ID_OP_SPECIAL) && (inst_i[5:0] == `ID_FN_JALR)) ||
		((inst_i[31:26] == `ID_OP_REGIMM) &&
		((inst_i[20:16] == `ID_RT_BLTZAL) || (inst_i[20:16] == `ID_RT_BGEZAL))));

	always_comb begin
		case (kind_i)
		id_pkg::BR_JUMP_ABS, id_pkg::BR_JUMP_REG: cond = 1'b1;
		id_pkg::BR_EQ:  cond = (reg1_i == reg2_i);
		id_pkg::BR_NE:  cond = (reg1_i != reg2_i);
		id_pkg::BR_GTZ: cond = !reg1_i[31] && (reg1_i != '0);
		id_pkg::BR_LEZ: cond = reg1_i[31] || (reg1_i == '0);
		id_pkg::BR_GEZ: cond = !reg1_i[31];
		id_pkg::BR_LTZ: cond = reg1_i[31];
		default:        cond = 1'b0;
		endcase
	end

	always_comb begin
		case (kind_i)
		id_pkg::BR_JUMP_ABS: target = abs_target;
		id_pkg::BR_JUMP_REG: target = reg1_i;
		default:             target = rel_target;
		endcase
	end

	always_comb begin
		branch_flag_o = 1'b0;
		next_inst_in_delayslot_o = 1'b0;
		branch_addr_o = '0;
		link_addr_o = '0;
		if (arst_n_i) begin
			if (cond) begin
				branch_flag_o = 1'b1;
				next_inst_in_delayslot_o = 1'b1;
				branch_addr_o = target;
			end
			if (is_link)
				link_addr_o = pc_plus_8;
		end
	end

endmodule

/* hdl/operand_forward.sv */
`timescale 1ns/10ps

module operand_forward (
	input  logic               read_i,
	input  id_pkg::reg_addr_t  addr_i,
	input  id_pkg::word_t      rf_data_i,
	input  id_pkg::word_t      imm_i,
	input  logic               ex_wreg_i,
	input  id_pkg::reg_addr_t  ex_wd_i,
	input  id_pkg::word_t      ex_wdata_i,
	input  logic               mem_wreg_i,
	input  id_pkg::reg_addr_t  mem_wd_i,
	input  id_pkg::word_t      mem_wdata_i,
	output id_pkg::word_t      operand_o
);

	// younger result wins, r0 is compared like any other register
	always_comb begin
		if (!read_i)
			operand_o = imm_i;
		else if (ex_wreg_i && (ex_wd_i == addr_i))
			operand_o = ex_wdata_i;
		else if (mem_wreg_i && (mem_wd_i == addr_i))
			operand_o = mem_wdata_i;
		else
			operand_o = rf_data_i;
	end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/10ps
`include "id_macros.svh"

module regfile (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               we_i,
	input  id_pkg::reg_addr_t  waddr_i,
	input  id_pkg::word_t      wdata_i,
	input  id_pkg::reg_addr_t  raddr1_i,
	input  id_pkg::reg_addr_t  raddr2_i,
	output id_pkg::word_t      rdata1_o,
	output id_pkg::word_t      rdata2_o
);

	id_pkg::word_t regs [`ID_REG_NUM];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `ID_REG_NUM; i++)
				regs[i] <= '0;
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// no write-through, a write shows up the next cycle
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* hdl/id_top.sv */
`timescale 1ns/10ps

module id_top (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  id_pkg::word_t         pc_i,
	input  id_pkg::word_t         inst_i,
	input  logic                  ex_wreg_i,
	input  id_pkg::reg_addr_t     ex_wd_i,
	input  id_pkg::word_t         ex_wdata_i,
	input  logic                  mem_wreg_i,
	input  id_pkg::reg_addr_t     mem_wd_i,
	input  id_pkg::word_t         mem_wdata_i,
	input  logic                  wb_we_i,
	input  id_pkg::reg_addr_t     wb_waddr_i,
	input  id_pkg::word_t         wb_wdata_i,
	input  logic                  is_in_delayslot_i,
	output id_pkg::aluop_t        aluop_o,
	output id_pkg::alusel_t       alusel_o,
	output id_pkg::word_t         reg1_o,
	output id_pkg::word_t         reg2_o,
	output id_pkg::reg_addr_t     wd_o,
	output logic                  wreg_o,
	output logic                  branch_flag_o,
	output id_pkg::word_t         branch_addr_o,
	output id_pkg::word_t         link_addr_o,
	output logic                  next_inst_in_delayslot_o,
	output logic                  is_in_delayslot_o
);

	logic reg1_read;
	logic reg2_read;
	id_pkg::reg_addr_t reg1_addr;
	id_pkg::reg_addr_t reg2_addr;
	id_pkg::word_t imm;
	id_pkg::word_t rf_data1;
	id_pkg::word_t rf_data2;
	id_pkg::branch_kind_t branch_kind;

	inst_decoder decoder_i (
		.arst_n_i      (arst_n_i),
		.inst_i        (inst_i),
		.aluop_o       (aluop_o),
		.alusel_o      (alusel_o),
		.wd_o          (wd_o),
		.wreg_o        (wreg_o),
		.reg1_read_o   (reg1_read),
		.reg2_read_o   (reg2_read),
		.reg1_addr_o   (reg1_addr),
		.reg2_addr_o   (reg2_addr),
		.imm_o         (imm),
		.branch_kind_o (branch_kind)
	);

	regfile regfile_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.we_i     (wb_we_i),
		.waddr_i  (wb_waddr_i),
		.wdata_i  (wb_wdata_i),
		.raddr1_i (reg1_addr),
		.raddr2_i (reg2_addr),
		.rdata1_o (rf_data1),
		.rdata2_o (rf_data2)
	);

	operand_forward fwd1_i (
		.read_i      (reg1_read),
		.addr_i      (reg1_addr),
		.rf_data_i   (rf_data1),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (reg1_o)
	);

	operand_forward fwd2_i (
		.read_i      (reg2_read),
		.addr_i      (reg2_addr),
		.rf_data_i   (rf_data2),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (reg2_o)
	);

	// jr/jalr targets use the forwarded rs value
	branch_unit branch_i (
		.arst_n_i                 (arst_n_i),
		.pc_i                     (pc_i),
		.inst_i                   (inst_i),
		.kind_i                   (branch_kind),
		.reg1_i                   (reg1_o),
		.reg2_i                   (reg2_o),
		.branch_flag_o            (branch_flag_o),
		.branch_addr_o            (branch_addr_o),
		.link_addr_o              (link_addr_o),
		.next_inst_in_delayslot_o (next_inst_in_delayslot_o)
	);

	assign is_in_delayslot_o = arst_n_i && is_in_delayslot_i;

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

/* verification/id_tb.sv */
`timescale 1ns/10ps
`include "id_macros.svh"

module id_tb;

	localparam int N_VEC = 150;
	localparam int TOTAL_CYCLES = 3 + 2 * `ID_REG_NUM + 4 * N_VEC;
	localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES;
	localparam logic [5:0] IMM_OPS [8] = '{`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI, `ID_OP_LUI,
		`ID_OP_ADDI, `ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU};
	localparam logic [5:0] R_FNS [16] = '{`ID_FN_OR, `ID_FN_AND, `ID_FN_XOR, `ID_FN_NOR,
		`ID_FN_SLLV, `ID_FN_SRLV, `ID_FN_SRAV, `ID_FN_ADD, `ID_FN_ADDU, `ID_FN_SUB,
		`ID_FN_SUBU, `ID_FN_SLT, `ID_FN_SLTU, `ID_FN_OR, `ID_FN_ADD, `ID_FN_SLT};

	logic clk;
	logic arst_n_i;
	logic [31:0] pc_i, inst_i, ex_wdata_i, mem_wdata_i, wb_wdata_i;
	logic ex_wreg_i, mem_wreg_i, wb_we_i, is_in_delayslot_i;
	logic [4:0] ex_wd_i, mem_wd_i, wb_waddr_i;
	id_pkg::aluop_t aluop_o;
	id_pkg::alusel_t alusel_o;
	logic [31:0] reg1_o, reg2_o, branch_addr_o, link_addr_o;
	logic [4:0] wd_o;
	logic wreg_o, branch_flag_o, next_inst_in_delayslot_o, is_in_delayslot_o;

	logic [31:0] model_regs [32];
	logic [31:0] lcg_state;
	int errors, checks, bad_tests, n_tests, cycles;

	tb_clock_gen #(.PERIOD_NS(4.0)) clock_i (.clk_o(clk));

	id_top dut_i (
		.clk(clk), .arst_n_i(arst_n_i), .pc_i(pc_i), .inst_i(inst_i),
		.ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
		.mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
		.wb_we_i(wb_we_i), .wb_waddr_i(wb_waddr_i), .wb_wdata_i(wb_wdata_i),
		.is_in_delayslot_i(is_in_delayslot_i),
		.aluop_o(aluop_o), .alusel_o(alusel_o), .reg1_o(reg1_o), .reg2_o(reg2_o),
		.wd_o(wd_o), .wreg_o(wreg_o), .branch_flag_o(branch_flag_o),
		.branch_addr_o(branch_addr_o), .link_addr_o(link_addr_o),
		.next_inst_in_delayslot_o(next_inst_in_delayslot_o),
		.is_in_delayslot_o(is_in_delayslot_o)
	);

	function automatic logic [31:0] rnd();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state ^ (lcg_state >> 15);
	endfunction

	// zero and negative values often so branch conditions get both outcomes
	function automatic logic [31:0] pick_val();
		logic [31:0] r;
		r = rnd();
		case (r[1:0])
		2'd0: return 32'd0;
		2'd1: return rnd() | 32'h8000_0000;
		default: return rnd();
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic ref_decode(input logic [31:0] inst, output logic [7:0] op,
			output logic r1, output logic r2, output logic [31:0] imm,
			output logic wr, output logic [4:0] wd);
		logic [5:0] opc;
		logic [5:0] fn;
		logic [4:0] rs, rt, sa;
		opc = inst[31:26];
		rs = inst[25:21];
		rt = inst[20:16];
		sa = inst[10:6];
		fn = inst[5:0];
		op = id_pkg::ALU_NOP;
		r1 = 1'b0;
		r2 = 1'b0;
		imm = 32'd0;
		wr = 1'b0;
		wd = inst[15:11];
		case (opc)
		`ID_OP_SPECIAL: begin
			case (fn)
			`ID_FN_OR: op = id_pkg::ALU_OR;
			`ID_FN_AND: op = id_pkg::ALU_AND;
			`ID_FN_XOR: op = id_pkg::ALU_XOR;
			`ID_FN_NOR: op = id_pkg::ALU_NOR;
			`ID_FN_SLLV, `ID_FN_SLL: op = id_pkg::ALU_SLL;
			`ID_FN_SRLV, `ID_FN_SRL: op = id_pkg::ALU_SRL;
			`ID_FN_SRAV, `ID_FN_SRA: op = id_pkg::ALU_SRA;
			`ID_FN_ADD: op = id_pkg::ALU_ADD;
			`ID_FN_ADDU: op = id_pkg::ALU_ADDU;
			`ID_FN_SUB: op = id_pkg::ALU_SUB;
			`ID_FN_SUBU: op = id_pkg::ALU_SUBU;
			`ID_FN_SLT: op = id_pkg::ALU_SLT;
			`ID_FN_SLTU: op = id_pkg::ALU_SLTU;
			`ID_FN_JR: op = id_pkg::ALU_JR;
			`ID_FN_JALR: op = id_pkg::ALU_JALR;
			default: op = id_pkg::ALU_NOP;
			endcase
			if (fn == `ID_FN_SLL || fn == `ID_FN_SRL || fn == `ID_FN_SRA) begin
				r2 = 1'b1;
				imm = {27'd0, sa};
				if (rs != 5'd0)
					op = id_pkg::ALU_NOP;
			end else begin
				r1 = 1'b1;
				r2 = (fn != `ID_FN_JR) && (fn != `ID_FN_JALR);
				if (sa != 5'd0)
					op = id_pkg::ALU_NOP;
			end
			wr = (fn != `ID_FN_JR);
		end
		`ID_OP_J: op = id_pkg::ALU_J;
		`ID_OP_JAL: begin
			op = id_pkg::ALU_JAL;
			wr = 1'b1;
			wd = 5'd31;
		end
		`ID_OP_BEQ, `ID_OP_BNE: begin
			op = (opc == `ID_OP_BEQ) ? id_pkg::ALU_BEQ : id_pkg::ALU_BNE;
			r1 = 1'b1;
			r2 = 1'b1;
		end
		`ID_OP_BLEZ, `ID_OP_BGTZ: begin
			op = (opc == `ID_OP_BLEZ) ? id_pkg::ALU_BLEZ : id_pkg::ALU_BGTZ;
			r1 = 1'b1;
		end
		`ID_OP_REGIMM: begin
			case (rt)
			`ID_RT_BLTZ: op = id_pkg::ALU_BLTZ;
			`ID_RT_BGEZ: op = id_pkg::ALU_BGEZ;
			`ID_RT_BLTZAL: op = id_pkg::ALU_BLTZAL;
			`ID_RT_BGEZAL: op = id_pkg::ALU_BGEZAL;
			default: op = id_pkg::ALU_NOP;
			endcase
			r1 = 1'b1;
			wr = (rt == `ID_RT_BLTZAL) || (rt == `ID_RT_BGEZAL);
			wd = 5'd31;
		end
		`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI: begin
			op = (opc == `ID_OP_ORI) ? id_pkg::ALU_OR :
				(opc == `ID_OP_ANDI) ? id_pkg::ALU_AND : id_pkg::ALU_XOR;
			imm = {16'd0, inst[15:0]};
		end
		`ID_OP_LUI: begin
			op = id_pkg::ALU_OR;
			imm = {inst[15:0], 16'd0};
		end
		`ID_OP_ADDI, `ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU: begin
			op = (opc == `ID_OP_ADDI) ? id_pkg::ALU_ADDI :
				(opc == `ID_OP_ADDIU) ? id_pkg::ALU_ADDIU :
				(opc == `ID_OP_SLTI) ? id_pkg::ALU_SLT : id_pkg::ALU_SLTU;
			imm = {{16{inst[15]}}, inst[15:0]};
		end
		default: op = id_pkg::ALU_NOP;
		endcase
		// every immediate form reads rs and writes rt
		if (opc >= `ID_OP_ADDI && opc <= `ID_OP_LUI) begin
			r1 = 1'b1;
			wr = 1'b1;
			wd = rt;
		end
		if (op == id_pkg::ALU_NOP) begin
			r1 = 1'b0;
			r2 = 1'b0;
			imm = 32'd0;
			wr = 1'b0;
		end
	endtask

	function automatic logic [2:0] sel_of(input logic [7:0] op);
		case (op)
		id_pkg::ALU_NOP: return id_pkg::RES_NOP;
		id_pkg::ALU_OR, id_pkg::ALU_AND, id_pkg::ALU_XOR, id_pkg::ALU_NOR:
			return id_pkg::RES_LOGIC;
		id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA: return id_pkg::RES_SHIFT;
		id_pkg::ALU_ADD, id_pkg::ALU_ADDU, id_pkg::ALU_ADDI, id_pkg::ALU_ADDIU,
		id_pkg::ALU_SUB, id_pkg::ALU_SUBU, id_pkg::ALU_SLT, id_pkg::ALU_SLTU:
			return id_pkg::RES_ARITH;
		default: return id_pkg::RES_JUMP_BRANCH;
		endcase
	endfunction

	function automatic logic [31:0] fwd_operand(input logic rd_en, input logic [4:0] addr,
			input logic [31:0] imm);
		if (!rd_en)
			return imm;
		if (ex_wreg_i && ex_wd_i == addr)
			return ex_wdata_i;
		if (mem_wreg_i && mem_wd_i == addr)
			return mem_wdata_i;
		return model_regs[addr];
	endfunction

	task automatic check_outputs();
		logic [7:0] op;
		logic r1, r2, wr, taken;
		logic [31:0] imm, a, b, pc4, tgt, link;
		logic [4:0] wd;
		ref_decode(inst_i, op, r1, r2, imm, wr, wd);
		a = fwd_operand(r1, inst_i[25:21], imm);
		b = fwd_operand(r2, inst_i[20:16], imm);
		pc4 = pc_i + 32'd4;
		tgt = pc4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
		link = 32'd0;
		case (op)
		id_pkg::ALU_J, id_pkg::ALU_JAL: begin
			taken = 1'b1;
			tgt = {pc4[31:28], inst_i[25:0], 2'b00};
		end
		id_pkg::ALU_JR, id_pkg::ALU_JALR: begin
			taken = 1'b1;
			tgt = a;
		end
		id_pkg::ALU_BEQ: taken = (a == b);
		id_pkg::ALU_BNE: taken = (a != b);
		id_pkg::ALU_BGTZ: taken = ($signed(a) > 0);
		id_pkg::ALU_BLEZ: taken = ($signed(a) <= 0);
		id_pkg::ALU_BGEZ, id_pkg::ALU_BGEZAL: taken = ($signed(a) >= 0);
		id_pkg::ALU_BLTZ, id_pkg::ALU_BLTZAL: taken = ($signed(a) < 0);
		default: taken = 1'b0;
		endcase
		if (!taken)
			tgt = 32'd0;
		if (op == id_pkg::ALU_JAL || op == id_pkg::ALU_JALR ||
				op == id_pkg::ALU_BGEZAL || op == id_pkg::ALU_BLTZAL)
			link = pc_i + 32'd8;
		compare("aluop_o", {24'd0, aluop_o}, {24'd0, op});
		compare("alusel_o", {29'd0, alusel_o}, {29'd0, sel_of(op)});
		compare("wreg_o", {31'd0, wreg_o}, {31'd0, wr});
		if (wr)
			compare("wd_o", {27'd0, wd_o}, {27'd0, wd});
		compare("reg1_o", reg1_o, a);
		compare("reg2_o", reg2_o, b);
		compare("branch_flag_o", {31'd0, branch_flag_o}, {31'd0, taken});
		compare("next_inst_in_delayslot_o", {31'd0, next_inst_in_delayslot_o}, {31'd0, taken});
		compare("branch_addr_o", branch_addr_o, tgt);
		compare("link_addr_o", link_addr_o, link);
		compare("is_in_delayslot_o", {31'd0, is_in_delayslot_o}, {31'd0, is_in_delayslot_i});
	endtask

	// ex and mem destinations land on rs, rt or elsewhere
	task automatic rand_fwd(input logic [4:0] rs, input logic [4:0] rt);
		logic [31:0] r;
		r = rnd();
		ex_wreg_i = r[0];
		ex_wd_i = r[2:1] == 2'd0 ? rs : r[2:1] == 2'd1 ? rt : r[20:16];
		ex_wdata_i = pick_val();
		mem_wreg_i = r[3];
		mem_wd_i = r[5:4] == 2'd0 ? rs : r[5:4] == 2'd1 ? rt : r[25:21];
		mem_wdata_i = r[6] ? ex_wdata_i : pick_val();
		pc_i = rnd() & 32'hffff_fffc;
		is_in_delayslot_i = r[7];
	endtask

	task automatic end_test(input string name, input int err_before);
		n_tests++;
		if (errors != err_before)
			bad_tests++;
		$display("test %s done, %0d errors", name, errors - err_before);
	endtask

	initial begin
		int e;
		logic [31:0] r, d;
		logic [5:0] opc;
		lcg_state = 32'd34;
		errors = 0;
		checks = 0;
		bad_tests = 0;
		n_tests = 0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'd0;
		arst_n_i = 1'b0;
		pc_i = 32'd0;
		inst_i = 32'hffff_ffff;
		ex_wreg_i = 1'b0;
		ex_wd_i = 5'd0;
		ex_wdata_i = 32'd0;
		mem_wreg_i = 1'b0;
		mem_wd_i = 5'd0;
		mem_wdata_i = 32'd0;
		wb_we_i = 1'b0;
		wb_waddr_i = 5'd0;
		wb_wdata_i = 32'd0;
		is_in_delayslot_i = 1'b1;

		e = errors;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			r = rnd();
			if (i == 2)
				arst_n_i = 1'b1;
			inst_i = (i == 2) ? 32'hffff_ffff : {`ID_OP_JAL, r[25:0]};
			is_in_delayslot_i = (i != 2);
			#1;
			compare("wreg_o", {31'd0, wreg_o}, 32'd0);
			compare("branch_flag_o", {31'd0, branch_flag_o}, 32'd0);
			compare("next_inst_in_delayslot_o", {31'd0, next_inst_in_delayslot_o}, 32'd0);
			compare("is_in_delayslot_o", {31'd0, is_in_delayslot_o}, 32'd0);
			compare("aluop_o", {24'd0, aluop_o}, 32'd0);
		end
		end_test("reset", e);

		e = errors;
		for (int i = 0; i < 32; i++) begin
			@(negedge clk);
			d = rnd();
			wb_we_i = 1'b1;
			wb_waddr_i = 5'(i);
			wb_wdata_i = d;
			inst_i = 32'hffff_ffff;
			#1;
			check_outputs();
			@(negedge clk);
			wb_we_i = 1'b0;
			if (i != 0)
				model_regs[i] = d;
			inst_i = {`ID_OP_SPECIAL, 5'(i), 5'd0, 5'd1, 5'd0, `ID_FN_OR};
			#1;
			check_outputs();
		end
		end_test("regfile round trip", e);

		e = errors;
		for (int i = 0; i < N_VEC; i++) begin
			@(negedge clk);
			r = rnd();
			if (r[0])
				inst_i = {`ID_OP_SPECIAL, 5'd0, r[20:6], 6'(r[1] ? `ID_FN_SRL :
					(r[2] ? `ID_FN_SRA : `ID_FN_SLL))};
			else
				inst_i = {IMM_OPS[r[31:29]], r[25:0]};
			rand_fwd(inst_i[25:21], inst_i[20:16]);
			#1;
			check_outputs();
		end
		end_test("immediate decode", e);

		e = errors;
		for (int i = 0; i < N_VEC; i++) begin
			@(negedge clk);
			r = rnd();
			inst_i = {`ID_OP_SPECIAL, r[25:11], 5'd0, R_FNS[r[31:28]]};
			rand_fwd(inst_i[25:21], inst_i[20:16]);
			#1;
			check_outputs();
		end
		end_test("forwarding priority", e);

		e = errors;
		for (int i = 0; i < N_VEC; i++) begin
			@(negedge clk);
			r = rnd();
			case (r[31:29])
			3'd0: inst_i = {`ID_OP_BEQ, r[25:0]};
			3'd1: inst_i = {`ID_OP_BNE, r[25:0]};
			3'd2: inst_i = {`ID_OP_BLEZ, r[25:0]};
			3'd3: inst_i = {`ID_OP_BGTZ, r[25:0]};
			3'd4: inst_i = {`ID_OP_REGIMM, r[25:21], `ID_RT_BLTZ, r[15:0]};
			default: inst_i = {`ID_OP_REGIMM, r[25:21], `ID_RT_BGEZ, r[15:0]};
			endcase
			rand_fwd(inst_i[25:21], inst_i[20:16]);
			ex_wreg_i = 1'b1;
			ex_wd_i = inst_i[25:21];
			mem_wreg_i = 1'b1;
			mem_wd_i = inst_i[20:16];
			#1;
			check_outputs();
		end
		end_test("branch decisions", e);

		e = errors;
		for (int i = 0; i < N_VEC; i++) begin
			@(negedge clk);
			r = rnd();
			opc = {2'b01, r[3:0]};
			case (r[31:29])
			3'd0: inst_i = {`ID_OP_J, r[25:0]};
			3'd1: inst_i = {`ID_OP_JAL, r[25:0]};
			3'd2: inst_i = {`ID_OP_SPECIAL, r[25:11], 5'd0, `ID_FN_JR};
			3'd3: inst_i = {`ID_OP_SPECIAL, r[25:16], 5'd31, 5'd0, `ID_FN_JALR};
			3'd4: inst_i = {`ID_OP_REGIMM, r[25:21], `ID_RT_BGEZAL, r[15:0]};
			3'd5: inst_i = {`ID_OP_REGIMM, r[25:21], `ID_RT_BLTZAL, r[15:0]};
			3'd6: inst_i = {opc, r[25:0]};
			default: inst_i = r[4] ? {`ID_OP_PREF, r[25:0]} :
				{`ID_OP_SPECIAL, r[25:6], `ID_FN_SYNC};
			endcase
			rand_fwd(inst_i[25:21], inst_i[20:16]);
			#1;
			check_outputs();
		end
		end_test("jumps and links", e);

		$display("summary: %0d tests, %0d with errors, %0d checks, %0d mismatches",
			n_tests, bad_tests, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		cycles = 0;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without reaching the end", cycles);
			$display("tests failed");
			$finish;
		end
	end

endmodule

/* all.f */
+incdir+common
common/id_pkg.sv
decode/inst_decoder.sv
decode/branch_unit.sv
hdl/operand_forward.sv
hdl/regfile.sv
hdl/id_top.sv
verification/tb_clock_gen.sv
verification/id_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module id_tb -o id_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build error, see build.log"
	exit 1
fi

./obj_dir/id_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulator exited with an error, see sim.log"
	exit 1
fi

if grep -q "tests failed" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi
echo "simulation clean"
exit 0
